/* sources.f */
rtl/acl_pkg.sv
rtl/spi_byte_shifter.sv
rtl/acl_sequencer.sv
rtl/acl_sample_packer.sv
rtl/acl_spi_top.sv
verif/acl_sensor_model.sv
verif/tb_acl_spi_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_acl_spi_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_acl_spi_top.sv */
`timescale 1ns/1ps

module tb_acl_spi_top;
	import acl_pkg::*;

	localparam int NUM_SAMPLES    = 4;
	localparam int BYTE_CYCLES    = 8 * CLKS_PER_BIT;
	localparam int TIMEOUT_CYCLES = POWERUP_CYCLES + CONFIG_WAIT_CYCLES
		+ NUM_SAMPLES * SAMPLE_PERIOD_CYCLES + 56000;   // Margin for frames and drain

	logic        iclk;
	logic        rst_n;
	logic        miso;
	logic        sclk;
	logic        mosi;
	logic        cs_n;
	acl_sample_t acl_data;
	logic        sample_valid;
	logic [63:0] frame_bytes;
	logic [47:0] served;
	int          frame_bits;
	int          frame_count;

	int   cyc = 0;
	int   rel_cyc = 0;
	int   cfg_end_cyc = 0;
	int   last_fall = 0;
	int   read_falls = 0;
	int   frames_seen = 0;
	int   read_frames_done = 0;
	int   samples_seen = 0;
	int   err_frame = 0;
	int   err_sample = 0;
	logic rst_seen = 1'b0;
	logic first_fall = 1'b0;
	logic cfg_done = 1'b0;
	logic prev_cs = 1'b1;

	acl_spi_top u_dut (
		.iclk         (iclk),
		.rst_n        (rst_n),
		.miso         (miso),
		.sclk         (sclk),
		.mosi         (mosi),
		.cs_n         (cs_n),
		.acl_data     (acl_data),
		.sample_valid (sample_valid)
	);

	acl_sensor_model u_sensor (
		.sclk        (sclk),
		.mosi        (mosi),
		.cs_n        (cs_n),
		.miso        (miso),
		.frame_bytes (frame_bytes),
		.frame_bits  (frame_bits),
		.frame_count (frame_count),
		.served      (served)
	);

	// Axis words are low byte first; keep the sign bit and four bits below it
	function automatic acl_sample_t ref_sample(input logic [47:0] bytes);
		axis_raw_t                  w;
		logic [AXIS_FIELD_BITS-1:0] f [3];
		int                         lsb;
		lsb = AXIS_FIELD_MSB - AXIS_FIELD_BITS + 1;
		for (int a = 0; a < 3; a++) begin
			w    = {bytes[16*a+8 +: 8], bytes[16*a +: 8]};
			f[a] = AXIS_FIELD_BITS'(w >> lsb);
		end
		return {f[0], f[1], f[2]};
	endfunction

	task automatic check_sample(input int n, input acl_sample_t got, input acl_sample_t exp,
		inout int errs);
		if (got !== exp) begin
			errs++;
			$display("ERROR at %0t ns: sample %0d is x=%h y=%h z=%h, expected x=%h y=%h z=%h",
				$time, n, got.x, got.y, got.z, exp.x, exp.y, exp.z);
		end
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp,
		inout int errs);
		if (got !== exp) begin
			errs++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cycles(input string what, input int got, input int lo, input int hi,
		inout int errs);
		if (got < lo || got > hi) begin
			errs++;
			$display("ERROR at %0t ns: %s took %0d cycles, expected %0d to %0d",
				$time, what, got, lo, hi);
		end
	endtask

	task automatic verify_frame(input int idx, inout int errs);
		int exp_bits;
		exp_bits = (idx == 0) ? 8 * CFG_FRAME_BYTES : 8 * READ_FRAME_BYTES;
		if (frame_bits != exp_bits) begin
			errs++;
			$display("ERROR at %0t ns: frame %0d has %0d bits, expected %0d",
				$time, idx, frame_bits, exp_bits);
		end
		if (idx == 0) begin
			check_byte("config command", frame_bytes[7:0], CMD_WRITE, errs);
			check_byte("config address", frame_bytes[15:8], REG_POWER_CTL, errs);
			check_byte("config value", frame_bytes[23:16], POWER_CTL_MEASURE, errs);
		end else begin
			check_byte("read command", frame_bytes[7:0], CMD_READ, errs);
			check_byte("read address", frame_bytes[15:8], REG_XDATA_L, errs);
			for (int k = READ_HDR_BYTES; k < READ_FRAME_BYTES; k++)
				check_byte($sformatf("read frame %0d byte %0d", idx, k),
					frame_bytes[8*k +: 8], 8'h00, errs);
		end
	endtask

	initial begin
		iclk = 1'b0;
		forever #4 iclk = ~iclk;   // 125 MHz sim clock standing in for iclk
	end

	// Bus monitor for reset state, frame contents and frame spacing
	always @(posedge iclk) begin
		cyc = cyc + 1;
		if (!rst_n) begin
			if (cyc > 1 && (!cs_n || sclk || sample_valid)) begin
				err_frame++;
				$display("ERROR at %0t ns: outputs not idle during reset", $time);
			end
		end else begin
			if (!rst_seen) begin
				rst_seen = 1'b1;
				rel_cyc  = cyc;
			end
			if (cs_n && sclk) begin
				err_frame++;
				$display("ERROR at %0t ns: sclk high while cs_n high", $time);
			end
			if (!first_fall && sample_valid) begin
				err_frame++;
				$display("ERROR at %0t ns: sample_valid before the first frame", $time);
			end
			if (prev_cs && !cs_n) begin
				if (!first_fall) begin
					first_fall = 1'b1;
					check_cycles("power-up wait", cyc - rel_cyc, POWERUP_CYCLES,
						POWERUP_CYCLES + BYTE_CYCLES, err_frame);
				end else begin
					read_falls++;
					if (read_falls == 1)
						check_cycles("settle wait", cyc - cfg_end_cyc, CONFIG_WAIT_CYCLES,
							CONFIG_WAIT_CYCLES + BYTE_CYCLES, err_frame);
					else
						check_cycles("sample period", cyc - last_fall, SAMPLE_PERIOD_CYCLES,
							SAMPLE_PERIOD_CYCLES, err_frame);
					last_fall = cyc;
				end
			end
			if (!prev_cs && cs_n && !cfg_done) begin
				cfg_done    = 1'b1;
				cfg_end_cyc = cyc;
			end
			prev_cs = cs_n;
			if (frame_count != frames_seen) begin   // Sensor closed a frame
				verify_frame(frames_seen, err_frame);
				if (frames_seen > 0)
					read_frames_done++;
				frames_seen++;
			end
		end
	end

	// Sample compare against the bytes the sensor served
	always @(posedge iclk) begin
		if (rst_n && sample_valid) begin
			samples_seen++;
			if (samples_seen != read_frames_done) begin
				err_sample++;
				$display("ERROR at %0t ns: sample pulse %0d after %0d read frames",
					$time, samples_seen, read_frames_done);
			end
			check_sample(samples_seen, acl_data, ref_sample(served), err_sample);
		end
	end

	initial begin
		wait (cyc >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles with %0d of %0d samples checked",
			cyc, samples_seen, NUM_SAMPLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge iclk);
		rst_n <= 1'b1;
		wait (samples_seen >= NUM_SAMPLES);
		repeat (8) @(posedge iclk);
		$display("Samples %0d, frames %0d, frame errors %0d, sample errors %0d",
			samples_seen, frames_seen, err_frame, err_sample);
		if (err_frame == 0 && err_sample == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verif/acl_sensor_model.sv */
`timescale 1ns/1ps

module acl_sensor_model (
	input  logic        sclk,
	input  logic        mosi,
	input  logic        cs_n,
	output logic        miso,
	output logic [63:0] frame_bytes,   // Bytes of the last frame, first byte at the bottom
	output int          frame_bits,    // Bits clocked in the last frame
	output int          frame_count,
	output logic [47:0] served         // Data bytes served in the last frame
);
	import acl_pkg::*;

	integer      seed = 32'hd84e3829;
	logic [31:0] rnd;
	logic        sclk_q = 1'b0;
	logic        cs_q = 1'b1;
	logic        miso_q = 1'b0;
	byte_t       rx_sr = '0;
	byte_t       tx_sr = '0;
	int          bit_in = 0;        // Bits of the current byte seen so far
	int          byte_idx = 0;
	int          total_bits = 0;
	int          n_frames = 0;
	logic [63:0] cur_frame = '0;
	logic [47:0] cur_served = '0;
	logic [63:0] last_frame = '0;
	logic [47:0] last_served = '0;
	int          last_bits = 0;

	assign miso        = miso_q;
	assign frame_bytes = last_frame;
	assign frame_bits  = last_bits;
	assign frame_count = n_frames;
	assign served      = last_served;

	always @(posedge sclk or negedge sclk or posedge cs_n or negedge cs_n) begin
		if (cs_n !== cs_q) begin
			if (!cs_n) begin                  // Frame opens
				bit_in     = 0;
				byte_idx   = 0;
				total_bits = 0;
				cur_frame  = '0;
				cur_served = '0;
				tx_sr      = '0;
				miso_q    <= 1'b0;
			end else begin                    // Frame closes, publish the log
				last_frame  = cur_frame;
				last_served = cur_served;
				last_bits   = total_bits;
				$display("Sensor: frame %0d, %0d bits, cmd %h addr %h",
					n_frames, total_bits, cur_frame[7:0], cur_frame[15:8]);
				n_frames = n_frames + 1;
			end
		end else if ((sclk !== sclk_q) && !cs_n) begin
			if (sclk) begin
				rx_sr      = {rx_sr[6:0], mosi};   // Mode 0 capture
				bit_in     = bit_in + 1;
				total_bits = total_bits + 1;
				if (bit_in == 8) begin
					if (byte_idx < 8)
						cur_frame[8*byte_idx +: 8] = rx_sr;
					byte_idx = byte_idx + 1;
					bit_in   = 0;
				end
			end else if (bit_in == 0) begin
				// Byte boundary: load data while the read burst runs
				if (cur_frame[7:0] == CMD_READ && byte_idx >= 2 && byte_idx < 8) begin
					rnd   = $random(seed);
					tx_sr = rnd[7:0];
					cur_served[8*(byte_idx-2) +: 8] = tx_sr;
				end else begin
					tx_sr = '0;
				end
				miso_q <= tx_sr[7];
			end else begin
				tx_sr   = {tx_sr[6:0], 1'b0};
				miso_q <= tx_sr[7];
			end
		end
		cs_q   = cs_n;
		sclk_q = sclk;
	end

endmodule

/* rtl/acl_spi_top.sv */
`timescale 1ns/1ps

module acl_spi_top (
	input  logic                 iclk,     // 4 MHz
	input  logic                 rst_n,
	input  logic                 miso,
	output logic                 sclk,     // 1 MHz while a byte shifts
	output logic                 mosi,
	output logic                 cs_n,
	output acl_pkg::acl_sample_t acl_data,
	output logic                 sample_valid
);
	import acl_pkg::*;

	spi_cmd_t    cmd;
	spi_rsp_t    rsp;
	burst_byte_t burst;
	logic        busy;
	logic        commit;

	acl_sequencer u_seq (
		.iclk   (iclk),
		.rst_n  (rst_n),
		.busy   (busy),
		.rsp    (rsp),
		.cmd    (cmd),
		.cs_n   (cs_n),
		.burst  (burst),
		.commit (commit)
	);

	spi_byte_shifter u_shift (
		.iclk  (iclk),
		.rst_n (rst_n),
		.cmd   (cmd),
		.miso  (miso),
		.sclk  (sclk),
		.mosi  (mosi),
		.busy  (busy),
		.rsp   (rsp)
	);

	acl_sample_packer u_pack (
		.iclk         (iclk),
		.rst_n        (rst_n),
		.burst        (burst),
		.commit       (commit),
		.acl_data     (acl_data),
		.sample_valid (sample_valid)
	);

endmodule

/* rtl/acl_sample_packer.sv */
`timescale 1ns/1ps

module acl_sample_packer (
	input  logic                 iclk,
	input  logic                 rst_n,
	input  acl_pkg::burst_byte_t burst,
	input  logic                 commit,
	output acl_pkg::acl_sample_t acl_data,
	output logic                 sample_valid
);
	import acl_pkg::*;

	axis_raw_t x_raw;
	axis_raw_t y_raw;
	axis_raw_t z_raw;

	// Bytes arrive X low, X high, Y low, Y high, Z low, Z high
	always_ff @(posedge iclk) begin
		if (burst.valid) begin
			case (burst.idx)
				3'd0:    x_raw[7:0]  <= burst.data;
				3'd1:    x_raw[15:8] <= burst.data;
				3'd2:    y_raw[7:0]  <= burst.data;
				3'd3:    y_raw[15:8] <= burst.data;
				3'd4:    z_raw[7:0]  <= burst.data;
				3'd5:    z_raw[15:8] <= burst.data;
				default: ;
			endcase
		end
	end

	// Publish sign plus four bits per axis, one cycle after commit
	always_ff @(posedge iclk or negedge rst_n) begin
		if (!rst_n) begin
			acl_data     <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= commit;
			if (commit) begin
				acl_data.x <= x_raw[AXIS_FIELD_MSB -: AXIS_FIELD_BITS];
				acl_data.y <= y_raw[AXIS_FIELD_MSB -: AXIS_FIELD_BITS];
				acl_data.z <= z_raw[AXIS_FIELD_MSB -: AXIS_FIELD_BITS];
			end
		end
	end

endmodule

/* rtl/acl_sequencer.sv */
`timescale 1ns/1ps

module acl_sequencer (
	input  logic                 iclk,
	input  logic                 rst_n,
	input  logic                 busy,
	input  acl_pkg::spi_rsp_t    rsp,
	output acl_pkg::spi_cmd_t    cmd,
	output logic                 cs_n,
	output acl_pkg::burst_byte_t burst,
	output logic                 commit
);
	import acl_pkg::*;

	typedef enum logic [2:0] {
		S_POWERUP,   // Sensor power-up wait
		S_CFG,       // Write frame to the power-control register
		S_SETTLE,    // Wait for the first conversion
		S_READ,      // Burst read frame
		S_CLOSE,     // End of read frame
		S_PERIOD     // Idle until the next sample slot
	} state_t;

	state_t                state;
	logic [WAIT_CNT_W-1:0] wait_cnt;   // Restarts at each cs_n fall and at the config frame end
	logic [WAIT_CNT_W-1:0] wait_last;
	logic [2:0]            byte_cnt;   // Byte in flight within the frame
	logic [2:0]            last_idx;
	logic                  send_req;   // Next byte waits for the shifter
	logic                  is_read;

	// Byte to send at a given position of a frame
	function automatic byte_t tx_sel(input logic rd, input logic [2:0] idx);
		byte_t b;
		b = '0;
		if (rd) begin
			case (idx)
				3'd0:    b = CMD_READ;
				3'd1:    b = REG_XDATA_L;
				default: b = '0;              // Dummy bytes clock the data out
			endcase
		end else begin
			case (idx)
				3'd0:    b = CMD_WRITE;
				3'd1:    b = REG_POWER_CTL;
				default: b = POWER_CTL_MEASURE;
			endcase
		end
		return b;
	endfunction

	assign is_read  = (state == S_READ);
	assign last_idx = is_read ? 3'(READ_FRAME_BYTES - 1) : 3'(CFG_FRAME_BYTES - 1);

	always_comb begin
		case (state)
			S_POWERUP: wait_last = WAIT_CNT_W'(POWERUP_CYCLES - 1);
			S_SETTLE:  wait_last = WAIT_CNT_W'(CONFIG_WAIT_CYCLES - 1);
			default:   wait_last = WAIT_CNT_W'(SAMPLE_PERIOD_CYCLES - 1);
		endcase
	end

	always_ff @(posedge iclk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_POWERUP;
			wait_cnt <= '0;
			byte_cnt <= '0;
			send_req <= 1'b0;
			cs_n     <= 1'b1;
			cmd      <= '0;
			burst    <= '0;
			commit   <= 1'b0;
		end else begin
			wait_cnt    <= wait_cnt + 1'b1;
			cmd.start   <= 1'b0;
			burst.valid <= 1'b0;
			commit      <= 1'b0;
			case (state)
				S_POWERUP, S_SETTLE, S_PERIOD: begin
					if (wait_cnt == wait_last) begin   // Open the next frame
						state    <= (state == S_POWERUP) ? S_CFG : S_READ;
						cs_n     <= 1'b0;
						wait_cnt <= '0;                // Period counts from the cs_n fall
						byte_cnt <= '0;
						send_req <= 1'b1;
					end
				end
				S_CFG, S_READ: begin
					if (send_req && !busy) begin
						cmd.start   <= 1'b1;
						cmd.tx_byte <= tx_sel(is_read, byte_cnt);
						send_req    <= 1'b0;
					end
					if (rsp.done) begin
						if (is_read && byte_cnt >= 3'(READ_HDR_BYTES)) begin
							burst.valid <= 1'b1;
							burst.idx   <= byte_cnt - 3'(READ_HDR_BYTES);
							burst.data  <= rsp.rx_byte;
						end
						if (byte_cnt == last_idx) begin
							if (is_read) begin
								state <= S_CLOSE;      // Last data byte goes out first
							end else begin
								cs_n     <= 1'b1;
								wait_cnt <= '0;        // Settle time counts from the cs_n rise
								state    <= S_SETTLE;
							end
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
							send_req <= 1'b1;
						end
					end
				end
				S_CLOSE: begin
					cs_n   <= 1'b1;
					commit <= 1'b1;
					state  <= S_PERIOD;
				end
				default: state <= S_POWERUP;
			endcase
		end
	end

	// Between frames the bus is parked and the shifter has finished
	a_cs_idle: assert property (@(posedge iclk) disable iff (!rst_n)
		(state inside {S_POWERUP, S_SETTLE, S_PERIOD}) |-> (cs_n && !busy))
		else $error("cs_n low or shifter busy between frames");

	a_commit_alone: assert property (@(posedge iclk) disable iff (!rst_n)
		commit |-> (!burst.valid && !busy))
		else $error("commit overlaps a burst byte or a busy shifter");

endmodule

/* rtl/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter (
	input  logic              iclk,
	input  logic              rst_n,
	input  acl_pkg::spi_cmd_t cmd,
	input  logic              miso,
	output logic              sclk,
	output logic              mosi,
	output logic              busy,
	output acl_pkg::spi_rsp_t rsp
);
	import acl_pkg::*;

	logic [PHASE_W-1:0] phase;     // iclk cycle within the current bit
	logic [2:0]         bit_cnt;   // Bit in flight, MSB first
	logic               done_q;
	byte_t              tx_sr;
	byte_t              rx_sr;
	byte_t              rx_byte_q;

	wire rise_now = busy && (phase == PHASE_W'(SCLK_HALF - 1));
	wire bit_end  = busy && (phase == PHASE_W'(CLKS_PER_BIT - 1));
	wire last_bit = (bit_cnt == 3'd7);

	// Bit sequencing and pin drive
	always_ff @(posedge iclk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			phase   <= '0;
			bit_cnt <= '0;
			sclk    <= 1'b0;
			mosi    <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				if (cmd.start) begin
					busy    <= 1'b1;
					phase   <= '0;
					bit_cnt <= '0;
					mosi    <= cmd.tx_byte[7];   // First bit out while sclk is low
				end
			end else begin
				phase <= phase + 1'b1;
				if (rise_now)
					sclk <= 1'b1;
				if (bit_end) begin
					sclk  <= 1'b0;
					phase <= '0;
					if (last_bit) begin
						busy   <= 1'b0;
						mosi   <= 1'b0;
						done_q <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						mosi    <= tx_sr[6];   // Next bit, set up on the falling edge
					end
				end
			end
		end
	end

	// Shift registers
	always_ff @(posedge iclk) begin
		if (!busy && cmd.start)
			tx_sr <= cmd.tx_byte;
		else if (bit_end)
			tx_sr <= {tx_sr[6:0], 1'b0};
		if (rise_now)
			rx_sr <= {rx_sr[6:0], miso};   // Mode 0 samples on rising sclk
		if (bit_end && last_bit)
			rx_byte_q <= rx_sr;
	end

	assign rsp.done    = done_q;
	assign rsp.rx_byte = rx_byte_q;

	a_no_start_busy: assert property (@(posedge iclk) disable iff (!rst_n)
		cmd.start |-> !busy)
		else $error("start issued while shifter busy");

	a_sclk_idle_low: assert property (@(posedge iclk) disable iff (!rst_n)
		!busy |-> !sclk)
		else $error("sclk high while shifter idle");

endmodule

/* rtl/acl_pkg.sv */
package acl_pkg;

	// One SPI data byte
	typedef logic [7:0] byte_t;

	// Position of a data byte in the burst, 0 to 5
	typedef logic [2:0] byte_idx_t;

	// One axis word, high byte above low byte
	typedef logic [15:0] axis_raw_t;

	// SPI bit timing at 4 MHz iclk
	localparam int CLKS_PER_BIT = 4;        // 1 MHz sclk
	localparam int SCLK_HALF    = 2;        // Low half, then high half
	localparam int PHASE_W      = $clog2(CLKS_PER_BIT);

	// Frame spacing, in iclk cycles
	localparam int POWERUP_CYCLES       = 24000;   // 6 ms
	localparam int CONFIG_WAIT_CYCLES   = 160000;  // 40 ms to first valid conversion
	localparam int SAMPLE_PERIOD_CYCLES = 40000;   // 10 ms, 100 Hz
	localparam int WAIT_CNT_W           = $clog2(CONFIG_WAIT_CYCLES);

	// Sensor commands and registers
	localparam byte_t CMD_WRITE         = 8'h0A;
	localparam byte_t CMD_READ          = 8'h0B;
	localparam byte_t REG_POWER_CTL     = 8'h2D;
	localparam byte_t POWER_CTL_MEASURE = 8'h02;  // Measurement mode
	localparam byte_t REG_XDATA_L       = 8'h0E;  // Auto-increments through Z high

	// Frame lengths in bytes
	localparam int CFG_FRAME_BYTES  = 3;   // Command, address, value
	localparam int READ_HDR_BYTES   = 2;   // Command, start address
	localparam int BURST_BYTES      = 6;   // X, Y, Z, low byte first
	localparam int READ_FRAME_BYTES = READ_HDR_BYTES + BURST_BYTES;

	// Field kept from each axis word: sign bit and the four bits below it
	localparam int AXIS_FIELD_MSB  = 11;
	localparam int AXIS_FIELD_BITS = 5;

	// Published sample, x at the top
	typedef struct packed {
		logic [AXIS_FIELD_BITS-1:0] x;
		logic [AXIS_FIELD_BITS-1:0] y;
		logic [AXIS_FIELD_BITS-1:0] z;
	} acl_sample_t;

	// Request to the byte shifter
	typedef struct packed {
		logic  start;    // One-cycle strobe
		byte_t tx_byte;
	} spi_cmd_t;

	// Response from the byte shifter
	typedef struct packed {
		logic  done;     // One-cycle pulse after the eighth bit
		byte_t rx_byte;  // Holds until the next done
	} spi_rsp_t;

	// Received data byte, labeled with its place in the burst
	typedef struct packed {
		logic      valid;
		byte_idx_t idx;
		byte_t     data;
	} burst_byte_t;

endpackage
